//--- mmu_top.f
+incdir+.
mmu_pkg.sv
mmu_if.sv
mmu_csr.sv
tlb.sv
addr_translate.sv
mmu_top.sv
tb_mmu_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
verilator --binary --timing -f mmu_top.f --top-module tb_mmu_top -o sim_mmu_top \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_mmu_top > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0

//--- tb_mmu_top.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tb_mmu_top;

    localparam int TEST_CYCLES = 400;
    // five times the expected test length
    localparam int MAX_CYCLES = 5 * TEST_CYCLES;

    logic           clk;
    logic           reset;
    logic           csr_we;
    logic [13:0]    csr_num;
    logic [31:0]    csr_wdata;
    logic           tlbwr;
    logic           fetch_req;
    mmu_pkg::va_t   fetch_va;
    logic           fetch_valid;
    logic [31:0]    fetch_pa;
    logic [5:0]     fetch_ecode;
    logic           data_req;
    mmu_pkg::va_t   data_va;
    logic           data_store;
    logic           data_valid;
    logic [31:0]    data_pa;
    logic [5:0]     data_ecode;

    // shadow registers and tlb entries
    logic           sh_da;
    logic [1:0]     sh_plv;
    logic [9:0]     sh_asid;
    logic [31:0]    sh_tlbidx;
    logic [31:0]    sh_ehi;
    logic [31:0]    sh_elo0;
    logic [31:0]    sh_elo1;
    logic [31:0]    sh_dmw0;
    logic [31:0]    sh_dmw1;
    logic           s_en   [16];
    logic [18:0]    s_vppn [16];
    logic [9:0]     s_asid [16];
    logic           s_g    [16];
    logic [31:0]    s_lo   [16][2];

    // expected {ecode, pa} per port
    logic [37:0]    fetch_q [$];
    logic [37:0]    data_q [$];
    logic [31:0]    lfsr_state = 32'h6c35ca81;
    int             error_count = 0;
    int             cycles = 0;

    mmu_top mmu_top_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    // half the time a page near the written tlb entries
    function automatic logic [31:0] random_va();
        logic [31:0] mode;
        logic [31:0] page;
        logic [31:0] low;
        mode = rand_bits(1);
        if (mode[0])
        begin
            page = rand_bits(3);
            low = rand_bits(13);
            return {12'b0, page[2:0], 4'b0, low[12:0]};
        end
        return rand_bits(32);
    endfunction

    function automatic logic [31:0] make_elo(input logic [19:0] ppn, input logic [1:0] plv,
                                             input logic g, input logic d, input logic v);
        return {4'b0, ppn, 1'b0, g, 2'b0, plv, d, v};
    endfunction

    function automatic logic [13:0] reg_number(input logic [2:0] pick);
        case (pick)
            3'd0: return `MMU_CSR_CRMD;
            3'd1: return `MMU_CSR_ASID;
            3'd2: return `MMU_CSR_TLBIDX;
            3'd3: return `MMU_CSR_TLBEHI;
            3'd4: return `MMU_CSR_TLBELO0;
            3'd5: return `MMU_CSR_TLBELO1;
            3'd6: return `MMU_CSR_DMW0;
            default: return `MMU_CSR_DMW1;
        endcase
    endfunction

    function automatic logic win_hit(input logic [31:0] dmw, input logic [31:0] va);
        return dmw[`MMU_DMW_VSEG] == va[31:29]
            && ((sh_plv == 2'd0 && dmw[`MMU_DMW_PLV0]) || (sh_plv == 2'd3 && dmw[`MMU_DMW_PLV3]));
    endfunction

    // expected {ecode, pa} from the shadow state
    function automatic logic [37:0] expect_xlat(input logic [31:0] va, input logic is_fetch,
                                                input logic store);
        logic [31:0] lo;
        logic [3:0]  idx;
        logic        found;
        found = 1'b0;
        idx = '0;
        if (sh_da)
        begin
            return {`MMU_ECODE_NONE, va};
        end
        if (win_hit(sh_dmw0, va))
        begin
            return {`MMU_ECODE_NONE, sh_dmw0[`MMU_DMW_PSEG], va[28:0]};
        end
        if (win_hit(sh_dmw1, va))
        begin
            return {`MMU_ECODE_NONE, sh_dmw1[`MMU_DMW_PSEG], va[28:0]};
        end
        for (int i = 0; i < 16; i++)
        begin
            if (!found && s_en[i] && s_vppn[i] == va[31:13] && (s_g[i] || s_asid[i] == sh_asid))
            begin
                found = 1'b1;
                idx = i[3:0];
            end
        end
        if (!found)
        begin
            return {`MMU_ECODE_TLBR, 32'h0};
        end
        lo = s_lo[idx][va[12]];
        if (!lo[`MMU_TLBELO_V])
        begin
            return {is_fetch ? `MMU_ECODE_PIF : (store ? `MMU_ECODE_PIS : `MMU_ECODE_PIL), 32'h0};
        end
        if (sh_plv > lo[`MMU_TLBELO_PLV])
        begin
            return {`MMU_ECODE_PPI, 32'h0};
        end
        if (store && !lo[`MMU_TLBELO_D])
        begin
            return {`MMU_ECODE_PME, 32'h0};
        end
        return {`MMU_ECODE_NONE, lo[`MMU_TLBELO_PPN], va[11:0]};
    endfunction

    task automatic shadow_reset();
        sh_da = 1'b1;
        sh_plv = 2'd0;
        sh_asid = '0;
        sh_tlbidx = '0;
        sh_ehi = '0;
        sh_elo0 = '0;
        sh_elo1 = '0;
        sh_dmw0 = '0;
        sh_dmw1 = '0;
        for (int i = 0; i < 16; i++)
        begin
            s_en[i] = 1'b0;
        end
    endtask

    // tlbwr copies the registers as they were before this edge's write
    task automatic shadow_update();
        logic [3:0] idx;
        idx = sh_tlbidx[`MMU_TLBIDX_INDEX];
        if (tlbwr)
        begin
            s_en[idx] = !sh_tlbidx[`MMU_TLBIDX_NE];
            s_vppn[idx] = sh_ehi[`MMU_TLBEHI_VPPN];
            s_asid[idx] = sh_asid;
            s_g[idx] = sh_elo0[`MMU_TLBELO_G] & sh_elo1[`MMU_TLBELO_G];
            s_lo[idx][0] = sh_elo0;
            s_lo[idx][1] = sh_elo1;
        end
        if (csr_we)
        begin
            case (csr_num)
                `MMU_CSR_CRMD:
                begin
                    sh_da = csr_wdata[`MMU_CRMD_DA];
                    sh_plv = csr_wdata[`MMU_CRMD_PLV];
                end
                `MMU_CSR_ASID:    sh_asid = csr_wdata[`MMU_ASID_ASID];
                `MMU_CSR_TLBIDX:  sh_tlbidx = csr_wdata;
                `MMU_CSR_TLBEHI:  sh_ehi = csr_wdata;
                `MMU_CSR_TLBELO0: sh_elo0 = csr_wdata;
                `MMU_CSR_TLBELO1: sh_elo1 = csr_wdata;
                `MMU_CSR_DMW0:    sh_dmw0 = csr_wdata;
                `MMU_CSR_DMW1:    sh_dmw1 = csr_wdata;
                default:
                begin
                end
            endcase
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input string port, input bit pending, input logic [37:0] exp,
                                input logic valid, input logic [31:0] pa, input logic [5:0] code);
        if (pending && valid !== 1'b1)
        begin
            error_count++;
            $display("%s port gave no result for its request, time %0t ns", port, $time);
        end
        else if (!pending && valid !== 1'b0)
        begin
            error_count++;
            $display("%s port gave a result without a request, time %0t ns", port, $time);
        end
        else if (pending)
        begin
            check_value({port, " pa"}, pa, exp[31:0]);
            check_value({port, " ecode"}, {26'b0, code}, {26'b0, exp[37:32]});
        end
    endtask

    // expectations at the rising edge, results one falling edge later
    always
    begin : compare
        logic [37:0] fexp;
        logic [37:0] dexp;
        bit          fpend;
        bit          dpend;
        @(posedge clk);
        if (reset)
        begin
            shadow_reset();
        end
        else
        begin
            if (fetch_req)
            begin
                fetch_q.push_back(expect_xlat(fetch_va, 1'b1, 1'b0));
            end
            if (data_req)
            begin
                data_q.push_back(expect_xlat(data_va, 1'b0, data_store));
            end
            shadow_update();
        end
        @(negedge clk);
        fexp = '0;
        dexp = '0;
        fpend = fetch_q.size() > 0;
        dpend = data_q.size() > 0;
        if (fpend)
        begin
            fexp = fetch_q.pop_front();
        end
        if (dpend)
        begin
            dexp = data_q.pop_front();
        end
        check_result("fetch", fpend, fexp, fetch_valid, fetch_pa, fetch_ecode);
        check_result("data", dpend, dexp, data_valid, data_pa, data_ecode);
    end

    initial
    begin
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
        $display("%0d errors in translation checks", error_count);
        $display(">>> FAIL");
        $finish;
    end

    task automatic next_cycle();
        @(negedge clk);
        csr_we = 1'b0;
        tlbwr = 1'b0;
        fetch_req = 1'b0;
        data_req = 1'b0;
        data_store = 1'b0;
    endtask

    task automatic csr_write(input logic [13:0] num, input logic [31:0] data);
        next_cycle();
        csr_we = 1'b1;
        csr_num = num;
        csr_wdata = data;
    endtask

    task automatic write_entry(input logic [3:0] idx, input logic ne, input logic [18:0] vppn,
                               input logic [31:0] elo0, input logic [31:0] elo1);
        csr_write(`MMU_CSR_TLBIDX, {ne, 27'b0, idx});
        csr_write(`MMU_CSR_TLBEHI, {vppn, 13'b0});
        csr_write(`MMU_CSR_TLBELO0, elo0);
        csr_write(`MMU_CSR_TLBELO1, elo1);
        next_cycle();
        tlbwr = 1'b1;
    endtask

    task automatic both_requests(input logic [31:0] fva, input logic [31:0] dva,
                                 input logic store);
        next_cycle();
        fetch_req = 1'b1;
        fetch_va = fva;
        data_req = 1'b1;
        data_va = dva;
        data_store = store;
    endtask

    task automatic seg_requests(input logic [2:0] seg);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        a = rand_bits(29);
        b = rand_bits(29);
        s = rand_bits(1);
        both_requests({seg, a[28:0]}, {seg, b[28:0]}, s[0]);
    endtask

    // both halves, load and store
    task automatic probe_page(input logic [18:0] vppn);
        logic [31:0] off;
        for (int k = 0; k < 4; k++)
        begin
            off = rand_bits(12);
            both_requests({vppn, k[1], off[11:0]}, {vppn, k[1], off[11:0]}, k[0]);
        end
    endtask

    task automatic probe_all();
        probe_page(19'h10);
        probe_page(19'h20);
        probe_page(19'h30);
        probe_page(19'h40);
        probe_page(19'h50);
        probe_page(19'h60);
    endtask

    task automatic random_cycle();
        logic [31:0] ctrl;
        logic [31:0] wd;
        ctrl = rand_bits(14);
        wd = rand_bits(32);
        next_cycle();
        fetch_req = ctrl[0];
        fetch_va = random_va();
        data_req = ctrl[1];
        data_va = random_va();
        data_store = ctrl[2];
        tlbwr = (ctrl[12:9] == 4'd0);
        if (ctrl[5:3] == 3'd0)
        begin
            csr_we = 1'b1;
            csr_num = reg_number(ctrl[8:6]);
            csr_wdata = wd;
            // DA mostly left clear so windows and tlb get used
            if (csr_num == `MMU_CSR_CRMD)
            begin
                csr_wdata[`MMU_CRMD_DA] = wd[3] & ctrl[13];
            end
            if (csr_num == `MMU_CSR_ASID)
            begin
                csr_wdata = {26'b0, wd[1:0], 4'h2};
            end
            if (csr_num == `MMU_CSR_TLBEHI)
            begin
                csr_wdata = {12'b0, wd[2:0], 17'b0};
            end
        end
    endtask

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        clk = 1'b0;
        reset = 1'b1;
        csr_we = 1'b0;
        csr_num = '0;
        csr_wdata = '0;
        tlbwr = 1'b0;
        fetch_req = 1'b0;
        fetch_va = '0;
        data_req = 1'b0;
        data_va = '0;
        data_store = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // direct address mode after reset
        repeat (20)
        begin
            a = rand_bits(32);
            b = rand_bits(32);
            s = rand_bits(1);
            both_requests(a, b, s[0]);
        end

        // windows, DMW0 seg 5 at plv 0 only, DMW1 seg 5 at plv 0 and 3
        csr_write(`MMU_CSR_DMW0, 32'hA000_0001);
        csr_write(`MMU_CSR_DMW1, 32'hA600_0009);
        csr_write(`MMU_CSR_CRMD, 32'h0);
        csr_write(14'h7ff, 32'hffff_ffff);
        repeat (8) seg_requests(3'd5);
        csr_write(`MMU_CSR_CRMD, 32'h3);
        repeat (8) seg_requests(3'd5);
        csr_write(`MMU_CSR_DMW1, 32'h8600_0009);
        repeat (6) seg_requests(3'd4);
        repeat (6) seg_requests(3'd5);
        csr_write(`MMU_CSR_CRMD, 32'h0);
        repeat (6) seg_requests(3'd4);

        // tlb entries, page 0x30 written with NE set
        csr_write(`MMU_CSR_ASID, 32'h12);
        write_entry(4'd0, 1'b0, 19'h10, make_elo(20'h11111, 2'd0, 1'b0, 1'b1, 1'b1),
                    make_elo(20'h22222, 2'd0, 1'b0, 1'b0, 1'b1));
        write_entry(4'd1, 1'b0, 19'h20, make_elo(20'h33333, 2'd0, 1'b1, 1'b1, 1'b1),
                    make_elo(20'h44444, 2'd0, 1'b1, 1'b1, 1'b1));
        write_entry(4'd2, 1'b1, 19'h30, make_elo(20'h12345, 2'd0, 1'b1, 1'b1, 1'b1),
                    make_elo(20'h54321, 2'd0, 1'b1, 1'b1, 1'b1));
        write_entry(4'd3, 1'b0, 19'h40, make_elo(20'h55555, 2'd0, 1'b0, 1'b1, 1'b0),
                    make_elo(20'h66666, 2'd0, 1'b0, 1'b0, 1'b1));
        write_entry(4'd5, 1'b0, 19'h50, make_elo(20'h77777, 2'd3, 1'b0, 1'b1, 1'b1),
                    make_elo(20'h08888, 2'd3, 1'b0, 1'b1, 1'b1));
        csr_write(`MMU_CSR_ASID, 32'h34);
        write_entry(4'd4, 1'b0, 19'h10, make_elo(20'h99999, 2'd0, 1'b0, 1'b1, 1'b1),
                    make_elo(20'haaaaa, 2'd0, 1'b0, 1'b1, 1'b1));
        csr_write(`MMU_CSR_ASID, 32'h12);
        probe_all();
        csr_write(`MMU_CSR_ASID, 32'h34);
        probe_all();
        csr_write(`MMU_CSR_ASID, 32'h55);
        probe_all();
        // plv 3 against the plv 0 and plv 3 pages of asid 0x12
        csr_write(`MMU_CSR_ASID, 32'h12);
        csr_write(`MMU_CSR_CRMD, 32'h3);
        probe_page(19'h10);
        probe_page(19'h50);
        csr_write(`MMU_CSR_CRMD, 32'h0);

        // mixed traffic
        repeat (200) random_cycle();
        repeat (3) next_cycle();
        @(posedge clk);

        $display("%0d errors in translation checks", error_count);
        if (error_count == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- mmu_top.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            csr_we,
    input  logic [13:0]     csr_num,
    input  logic [31:0]     csr_wdata,
    input  logic            tlbwr,
    input  logic            fetch_req,
    input  mmu_pkg::va_t    fetch_va,
    output logic            fetch_valid,
    output logic [31:0]     fetch_pa,
    output logic [5:0]      fetch_ecode,
    input  logic            data_req,
    input  mmu_pkg::va_t    data_va,
    input  logic            data_store,
    output logic            data_valid,
    output logic [31:0]     data_pa,
    output logic [5:0]      data_ecode
);

    logic                       tlb_we;
    logic [`MMU_TLB_IDX_W-1:0]  tlb_windex;
    logic                       tlb_wne;
    logic [18:0]                tlb_wvppn;
    logic [9:0]                 tlb_wasid;
    logic                       tlb_wg;
    logic [31:0]                tlb_welo0;
    logic [31:0]                tlb_welo1;

    mmu_cfg_if    cfg_bus ();
    tlb_lookup_if fetch_lu ();
    tlb_lookup_if data_lu ();

    mmu_csr csr_i (
        .clk        (clk),
        .reset      (reset),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wdata  (csr_wdata),
        .tlbwr      (tlbwr),
        .cfg        (cfg_bus.source),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wne    (tlb_wne),
        .tlb_wvppn  (tlb_wvppn),
        .tlb_wasid  (tlb_wasid),
        .tlb_wg     (tlb_wg),
        .tlb_welo0  (tlb_welo0),
        .tlb_welo1  (tlb_welo1)
    );

    tlb tlb_i (
        .clk          (clk),
        .reset        (reset),
        .tlb_we       (tlb_we),
        .tlb_windex   (tlb_windex),
        .tlb_wne      (tlb_wne),
        .tlb_wvppn    (tlb_wvppn),
        .tlb_wasid    (tlb_wasid),
        .tlb_wg       (tlb_wg),
        .tlb_welo0    (tlb_welo0),
        .tlb_welo1    (tlb_welo1),
        .fetch_lookup (fetch_lu.responder),
        .data_lookup  (data_lu.responder)
    );

    // fetch never stores
    addr_translate #(.IS_FETCH(1'b1)) fetch_xlat (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg_bus.sink),
        .lookup    (fetch_lu.requester),
        .req       (fetch_req),
        .va        (fetch_va),
        .store     (1'b0),
        .res_valid (fetch_valid),
        .pa        (fetch_pa),
        .ecode     (fetch_ecode)
    );

    addr_translate #(.IS_FETCH(1'b0)) data_xlat (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg_bus.sink),
        .lookup    (data_lu.requester),
        .req       (data_req),
        .va        (data_va),
        .store     (data_store),
        .res_valid (data_valid),
        .pa        (data_pa),
        .ecode     (data_ecode)
    );

endmodule

//--- addr_translate.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module addr_translate #(
    parameter bit IS_FETCH = 1'b0
) (
    input  logic                clk,
    input  logic                reset,
    mmu_cfg_if.sink             cfg,
    tlb_lookup_if.requester     lookup,
    input  logic                req,
    input  mmu_pkg::va_t        va,
    input  logic                store,
    output logic                res_valid,
    output logic [31:0]         pa,
    output logic [5:0]          ecode
);

    logic        dmw0_hit;
    logic        dmw1_hit;
    logic [5:0]  inval_code;
    logic [31:0] pa_next;
    logic [5:0]  ecode_next;

    // window applies on a segment match at an enabled privilege level
    function automatic logic dmw_match(
        input logic [31:0] dmw,
        input logic [2:0]  vseg,
        input logic [1:0]  plv
    );
        return dmw[`MMU_DMW_VSEG] == vseg
            && ((plv == 2'd0 && dmw[`MMU_DMW_PLV0])
             || (plv == 2'd3 && dmw[`MMU_DMW_PLV3]));
    endfunction

    assign lookup.va   = va;
    assign lookup.asid = cfg.asid;

    assign dmw0_hit = dmw_match(cfg.dmw0, va.win.vseg, cfg.crmd_plv);
    assign dmw1_hit = dmw_match(cfg.dmw1, va.win.vseg, cfg.crmd_plv);

    // invalid page code depends on the kind of access
    assign inval_code = IS_FETCH ? `MMU_ECODE_PIF
                      : (store ? `MMU_ECODE_PIS : `MMU_ECODE_PIL);

    always_comb
    begin
        pa_next    = '0;
        ecode_next = `MMU_ECODE_NONE;
        if (cfg.crmd_da)
        begin
            pa_next = va;
        end
        else if (dmw0_hit)
        begin
            pa_next = {cfg.dmw0[`MMU_DMW_PSEG], va.win.seg_offset};
        end
        else if (dmw1_hit)
        begin
            pa_next = {cfg.dmw1[`MMU_DMW_PSEG], va.win.seg_offset};
        end
        else if (!lookup.found)
        begin
            ecode_next = `MMU_ECODE_TLBR;
        end
        else if (!lookup.v)
        begin
            ecode_next = inval_code;
        end
        else if (cfg.crmd_plv > lookup.plv)
        begin
            ecode_next = `MMU_ECODE_PPI;
        end
        else if (store && !lookup.d)
        begin
            ecode_next = `MMU_ECODE_PME;
        end
        else
        begin
            pa_next = {lookup.ppn, va.page.page_offset};
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            res_valid <= 1'b0;
        end
        else
        begin
            res_valid <= req;
        end
    end

    // result held until the next request
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            pa    <= pa_next;
            ecode <= ecode_next;
        end
    end

endmodule

//--- tlb.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        tlb_we,
    input  logic [`MMU_TLB_IDX_W-1:0]   tlb_windex,
    input  logic                        tlb_wne,
    input  logic [18:0]                 tlb_wvppn,
    input  logic [9:0]                  tlb_wasid,
    input  logic                        tlb_wg,
    input  logic [31:0]                 tlb_welo0,
    input  logic [31:0]                 tlb_welo1,
    tlb_lookup_if.responder             fetch_lookup,
    tlb_lookup_if.responder             data_lookup
);

    localparam int ENTRIES = `MMU_TLB_ENTRIES;

    logic        e_en   [ENTRIES];
    logic [18:0] e_vppn [ENTRIES];
    logic [9:0]  e_asid [ENTRIES];
    logic        e_g    [ENTRIES];
    // second index is the half, 0 even and 1 odd
    logic [19:0] e_ppn  [ENTRIES][2];
    logic [1:0]  e_plv  [ENTRIES][2];
    logic        e_d    [ENTRIES][2];
    logic        e_v    [ENTRIES][2];

    // search all entries, lowest matching index wins
    // result packs {found, ppn, plv, d, v}
    function automatic logic [24:0] search(input mmu_pkg::va_t va, input logic [9:0] asid);
        logic [24:0] hit;
        logic        odd;
        hit = '0;
        odd = va.page.odd;
        for (int i = ENTRIES - 1; i >= 0; i--)
        begin
            if (e_en[i] && e_vppn[i] == va.page.vppn && (e_g[i] || e_asid[i] == asid))
            begin
                hit = {1'b1, e_ppn[i][odd], e_plv[i][odd], e_d[i][odd], e_v[i][odd]};
            end
        end
        return hit;
    endfunction

    // entry enables, all cleared by reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < ENTRIES; i++)
            begin
                e_en[i] <= 1'b0;
            end
        end
        else if (tlb_we)
        begin
            e_en[tlb_windex] <= ~tlb_wne;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tlb_we)
        begin
            e_vppn[tlb_windex]   <= tlb_wvppn;
            e_asid[tlb_windex]   <= tlb_wasid;
            e_g[tlb_windex]      <= tlb_wg;
            e_ppn[tlb_windex][0] <= tlb_welo0[`MMU_TLBELO_PPN];
            e_plv[tlb_windex][0] <= tlb_welo0[`MMU_TLBELO_PLV];
            e_d[tlb_windex][0]   <= tlb_welo0[`MMU_TLBELO_D];
            e_v[tlb_windex][0]   <= tlb_welo0[`MMU_TLBELO_V];
            e_ppn[tlb_windex][1] <= tlb_welo1[`MMU_TLBELO_PPN];
            e_plv[tlb_windex][1] <= tlb_welo1[`MMU_TLBELO_PLV];
            e_d[tlb_windex][1]   <= tlb_welo1[`MMU_TLBELO_D];
            e_v[tlb_windex][1]   <= tlb_welo1[`MMU_TLBELO_V];
        end
    end

    // both ports answer in the same cycle
    assign {fetch_lookup.found, fetch_lookup.ppn, fetch_lookup.plv,
            fetch_lookup.d, fetch_lookup.v} = search(fetch_lookup.va, fetch_lookup.asid);

    assign {data_lookup.found, data_lookup.ppn, data_lookup.plv,
            data_lookup.d, data_lookup.v} = search(data_lookup.va, data_lookup.asid);

endmodule

//--- mmu_csr.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_csr (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        csr_we,
    input  logic [13:0]                 csr_num,
    input  logic [31:0]                 csr_wdata,
    input  logic                        tlbwr,
    mmu_cfg_if.source                   cfg,
    output logic                        tlb_we,
    output logic [`MMU_TLB_IDX_W-1:0]   tlb_windex,
    output logic                        tlb_wne,
    output logic [18:0]                 tlb_wvppn,
    output logic [9:0]                  tlb_wasid,
    output logic                        tlb_wg,
    output logic [31:0]                 tlb_welo0,
    output logic [31:0]                 tlb_welo1
);

    logic [1:0]                 crmd_plv;
    logic                       crmd_da;
    logic [9:0]                 asid;
    logic [`MMU_TLB_IDX_W-1:0]  tlbidx_index;
    logic                       tlbidx_ne;
    logic [18:0]                tlbehi_vppn;
    logic [31:0]                tlbelo0;
    logic [31:0]                tlbelo1;
    logic [31:0]                dmw0;
    logic [31:0]                dmw1;

    // keep only the architected TLBELO fields
    function automatic logic [31:0] elo_fields(input logic [31:0] w);
        logic [31:0] f;
        f = '0;
        f[`MMU_TLBELO_V]   = w[`MMU_TLBELO_V];
        f[`MMU_TLBELO_D]   = w[`MMU_TLBELO_D];
        f[`MMU_TLBELO_PLV] = w[`MMU_TLBELO_PLV];
        f[`MMU_TLBELO_MAT] = w[`MMU_TLBELO_MAT];
        f[`MMU_TLBELO_G]   = w[`MMU_TLBELO_G];
        f[`MMU_TLBELO_PPN] = w[`MMU_TLBELO_PPN];
        return f;
    endfunction

    // same for a window register
    function automatic logic [31:0] dmw_fields(input logic [31:0] w);
        logic [31:0] f;
        f = '0;
        f[`MMU_DMW_PLV0] = w[`MMU_DMW_PLV0];
        f[`MMU_DMW_PLV3] = w[`MMU_DMW_PLV3];
        f[`MMU_DMW_MAT]  = w[`MMU_DMW_MAT];
        f[`MMU_DMW_PSEG] = w[`MMU_DMW_PSEG];
        f[`MMU_DMW_VSEG] = w[`MMU_DMW_VSEG];
        return f;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // direct address mode, kernel level
            crmd_plv     <= 2'd0;
            crmd_da      <= 1'b1;
            asid         <= '0;
            tlbidx_index <= '0;
            tlbidx_ne    <= 1'b0;
            tlbehi_vppn  <= '0;
            tlbelo0      <= '0;
            tlbelo1      <= '0;
            dmw0         <= '0;
            dmw1         <= '0;
        end
        else if (csr_we)
        begin
            case (csr_num)
                `MMU_CSR_CRMD:
                begin
                    crmd_plv <= csr_wdata[`MMU_CRMD_PLV];
                    crmd_da  <= csr_wdata[`MMU_CRMD_DA];
                end
                `MMU_CSR_ASID:    asid <= csr_wdata[`MMU_ASID_ASID];
                `MMU_CSR_TLBIDX:
                begin
                    tlbidx_index <= csr_wdata[`MMU_TLBIDX_INDEX];
                    tlbidx_ne    <= csr_wdata[`MMU_TLBIDX_NE];
                end
                `MMU_CSR_TLBEHI:  tlbehi_vppn <= csr_wdata[`MMU_TLBEHI_VPPN];
                `MMU_CSR_TLBELO0: tlbelo0 <= elo_fields(csr_wdata);
                `MMU_CSR_TLBELO1: tlbelo1 <= elo_fields(csr_wdata);
                `MMU_CSR_DMW0:    dmw0 <= dmw_fields(csr_wdata);
                `MMU_CSR_DMW1:    dmw1 <= dmw_fields(csr_wdata);
                default:
                begin
                end
            endcase
        end
    end

    assign cfg.crmd_da  = crmd_da;
    assign cfg.crmd_plv = crmd_plv;
    assign cfg.asid     = asid;
    assign cfg.dmw0     = dmw0;
    assign cfg.dmw1     = dmw1;

    // tlbwr copies the staged entry from the current register values
    assign tlb_we     = tlbwr;
    assign tlb_windex = tlbidx_index;
    assign tlb_wne    = tlbidx_ne;
    assign tlb_wvppn  = tlbehi_vppn;
    assign tlb_wasid  = asid;
    // entry is global only if both halves say so
    assign tlb_wg     = tlbelo0[`MMU_TLBELO_G] & tlbelo1[`MMU_TLBELO_G];
    assign tlb_welo0  = tlbelo0;
    assign tlb_welo1  = tlbelo1;

endmodule

//--- mmu_if.sv
`timescale 1ns/1ps

// translation controls, from the register block to both translators
interface mmu_cfg_if;
    logic        crmd_da;
    logic [1:0]  crmd_plv;
    logic [9:0]  asid;
    // raw window words, decoded by the translators
    logic [31:0] dmw0;
    logic [31:0] dmw1;

    modport source (output crmd_da, crmd_plv, asid, dmw0, dmw1);
    modport sink (input crmd_da, crmd_plv, asid, dmw0, dmw1);
endinterface

// one combinational tlb search port
interface tlb_lookup_if;
    mmu_pkg::va_t va;
    logic [9:0]   asid;
    logic         found;
    logic [19:0]  ppn;
    logic [1:0]   plv;
    logic         d;
    logic         v;

    modport requester (
        output va,
        output asid,
        input  found,
        input  ppn,
        input  plv,
        input  d,
        input  v
    );
    modport responder (
        input  va,
        input  asid,
        output found,
        output ppn,
        output plv,
        output d,
        output v
    );
endinterface

//--- mmu_pkg.sv
package mmu_pkg;

    // one virtual address word, seen as a 4 KB page address by the tlb
    // and as a segment address by the direct mapping windows
    typedef union packed {
        struct packed {
            logic [18:0] vppn;
            logic        odd;
            logic [11:0] page_offset;
        } page;
        struct packed {
            logic [2:0]  vseg;
            logic [28:0] seg_offset;
        } win;
    } va_t;

endpackage

//--- mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// tlb geometry
`define MMU_TLB_ENTRIES     16
`define MMU_TLB_IDX_W       4

// register numbers
`define MMU_CSR_CRMD        14'h000
`define MMU_CSR_ASID        14'h018
`define MMU_CSR_TLBIDX      14'h010
`define MMU_CSR_TLBEHI      14'h011
`define MMU_CSR_TLBELO0     14'h012
`define MMU_CSR_TLBELO1     14'h013
`define MMU_CSR_DMW0        14'h180
`define MMU_CSR_DMW1        14'h181

// field positions, used as bit selects
`define MMU_CRMD_PLV        1:0
`define MMU_CRMD_DA         3
`define MMU_ASID_ASID       9:0
`define MMU_TLBIDX_INDEX    3:0
`define MMU_TLBIDX_NE       31
`define MMU_TLBEHI_VPPN     31:13
`define MMU_TLBELO_V        0
`define MMU_TLBELO_D        1
`define MMU_TLBELO_PLV      3:2
`define MMU_TLBELO_MAT      5:4
`define MMU_TLBELO_G        6
`define MMU_TLBELO_PPN      27:8
`define MMU_DMW_PLV0        0
`define MMU_DMW_PLV3        3
`define MMU_DMW_MAT         5:4
`define MMU_DMW_PSEG        27:25
`define MMU_DMW_VSEG        31:29

// translation exception codes
`define MMU_ECODE_NONE      6'h00
`define MMU_ECODE_PIL       6'h01
`define MMU_ECODE_PIS       6'h02
`define MMU_ECODE_PIF       6'h03
`define MMU_ECODE_PME       6'h04
`define MMU_ECODE_PPI       6'h07
`define MMU_ECODE_TLBR      6'h3f

`endif
